// File: common/issue_settings.svh
`ifndef ISSUE_SETTINGS_SVH
`define ISSUE_SETTINGS_SVH

// ROB size and tag width go together
`define ISSUE_ROB_DEPTH 8
`define ISSUE_TAG_W 3

// ALU reservation stations outside the issue stage
`define ISSUE_ALU_RS 3

// Datapath width
`define ISSUE_WORD_W 16

`endif

// File: common/lc3b_pkg.sv
`include "issue_settings.svh"

package lc3b_pkg;

	typedef logic [`ISSUE_WORD_W-1:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [`ISSUE_TAG_W-1:0] rob_tag_t;

	// LC-3b opcode field, only the ops handled by issue
	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_jsr = 4'b0100,	// JSR or JSRR by bit 11
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_lea = 4'b1110
	} lc3b_opcode;

	// One register status entry
	typedef struct packed
	{
		logic busy;		// Waiting on a ROB entry
		rob_tag_t tag;		// Producer
		lc3b_word data;
	} reg_entry_t;

	// Common data bus broadcast
	typedef struct packed
	{
		logic valid;
		rob_tag_t tag;
		lc3b_word data;
	} cdb_t;

endpackage

// File: common/issue_ifs.sv
`timescale 1ns/1ps

// Register status lookups from issue, plus the commit path from the ROB
interface reg_port_if;
	import lc3b_pkg::*;

	lc3b_reg sr1_idx;
	lc3b_reg sr2_idx;
	lc3b_reg dest_idx;
	logic set_busy;
	lc3b_reg busy_reg;
	rob_tag_t busy_tag;
	reg_entry_t sr1_entry;
	reg_entry_t sr2_entry;
	reg_entry_t dest_entry;
	logic commit_valid;
	lc3b_reg commit_reg;
	rob_tag_t commit_tag;
	lc3b_word commit_value;
	logic commit_has_dest;

	modport issue (
		output sr1_idx, sr2_idx, dest_idx, set_busy, busy_reg, busy_tag,
		input sr1_entry, sr2_entry, dest_entry
	);

	// The table sees both issue updates and commits
	modport reg_table (
		input sr1_idx, sr2_idx, dest_idx, set_busy, busy_reg, busy_tag,
		input commit_valid, commit_reg, commit_tag, commit_value, commit_has_dest,
		output sr1_entry, sr2_entry, dest_entry
	);

	modport commit (
		output commit_valid, commit_reg, commit_tag, commit_value, commit_has_dest
	);
endinterface

// Allocation and operand reads into the ROB
interface rob_port_if;
	import lc3b_pkg::*;

	logic alloc;
	lc3b_reg alloc_dest;
	logic alloc_has_dest;
	lc3b_word alloc_value;
	logic alloc_value_valid;
	rob_tag_t rd_tag1;
	rob_tag_t rd_tag2;
	rob_tag_t tail_tag;
	logic full;
	lc3b_word rd_value1;
	logic rd_valid1;
	lc3b_word rd_value2;
	logic rd_valid2;

	modport issue (
		output alloc, alloc_dest, alloc_has_dest, alloc_value, alloc_value_valid,
		output rd_tag1, rd_tag2,
		input tail_tag, full, rd_value1, rd_valid1, rd_value2, rd_valid2
	);

	modport rob (
		input alloc, alloc_dest, alloc_has_dest, alloc_value, alloc_value_valid,
		input rd_tag1, rd_tag2,
		output tail_tag, full, rd_value1, rd_valid1, rd_value2, rd_valid2
	);
endinterface

// File: design/reg_status.sv
`timescale 1ns/1ps

module reg_status (
	input logic clk,
	input logic rst_n,
	reg_port_if.reg_table regs
);
	import lc3b_pkg::*;

	reg_entry_t entries [8];

	// Combinational lookups for the instruction at issue
	assign regs.sr1_entry = entries[regs.sr1_idx];
	assign regs.sr2_entry = entries[regs.sr2_idx];
	assign regs.dest_entry = entries[regs.dest_idx];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
				entries[i] <= '0;
		end
		else
		begin
			// Only the newest producer may clear busy
			if (regs.commit_valid && regs.commit_has_dest
				&& entries[regs.commit_reg].tag == regs.commit_tag)
			begin
				entries[regs.commit_reg].busy <= 1'b0;
				entries[regs.commit_reg].data <= regs.commit_value;
			end
			// Later assignment, so issue wins over commit
			if (regs.set_busy)
			begin
				entries[regs.busy_reg].busy <= 1'b1;
				entries[regs.busy_reg].tag <= regs.busy_tag;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		regs.set_busy |-> !$isunknown(regs.busy_reg));

endmodule

// File: issue/issue_control.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module issue_control (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word instr,
	input logic instr_valid,
	input lc3b_pkg::lc3b_word curr_pc,
	input logic predict_bit,
	input logic [`ISSUE_ALU_RS-1:0] alu_busy,
	input logic ldst_full,
	input lc3b_pkg::cdb_t cdb,
	reg_port_if.issue regs,
	rob_port_if.issue rob,
	output logic stall,
	output logic pcmux_sel,
	output lc3b_pkg::lc3b_word br_pc,
	output logic alu_issue,
	output logic [1:0] alu_station,
	output lc3b_pkg::lc3b_opcode alu_op,
	output lc3b_pkg::lc3b_word alu_vj,
	output lc3b_pkg::lc3b_word alu_vk,
	output lc3b_pkg::rob_tag_t alu_qj,
	output lc3b_pkg::rob_tag_t alu_qk,
	output logic alu_j_ready,
	output logic alu_k_ready,
	output lc3b_pkg::rob_tag_t alu_dest,
	output logic ldst_issue,
	output lc3b_pkg::lc3b_opcode ldst_op,
	output lc3b_pkg::lc3b_word ldst_offset,
	output lc3b_pkg::lc3b_word ldst_vbase,
	output lc3b_pkg::rob_tag_t ldst_qbase,
	output logic ldst_base_ready,
	output lc3b_pkg::lc3b_word ldst_vsrc,
	output lc3b_pkg::rob_tag_t ldst_qsrc,
	output logic ldst_src_ready,
	output lc3b_pkg::rob_tag_t ldst_dest
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_word imm5;
	lc3b_word offset6;
	lc3b_word offset9;
	lc3b_word offset11;
	lc3b_word pc_next;
	logic is_alu;
	logic is_ldst;
	logic is_str;
	logic is_jsr;
	logic reg_jump;		// JMP or JSRR
	logic live;
	logic issue;
	logic shadow;
	reg_entry_t op2_entry;
	lc3b_word j_value;
	lc3b_word k_value;
	logic j_ready;
	logic k_ready;

	// Register first, then CDB bypass, then ROB; otherwise wait on the tag
	function automatic logic resolve(
		input reg_entry_t ent,
		input cdb_t bus,
		input lc3b_word rob_value,
		input logic rob_valid,
		output lc3b_word value
	);
		logic ready;
		ready = 1'b1;
		if (!ent.busy)
			value = ent.data;
		else if (bus.valid && bus.tag == ent.tag)
			value = bus.data;
		else if (rob_valid)
			value = rob_value;
		else
		begin
			value = '0;
			ready = 1'b0;
		end
		return ready;
	endfunction

	assign opcode = lc3b_opcode'(instr[15:12]);
	assign imm5 = lc3b_word'(signed'(instr[4:0]));
	assign offset6 = lc3b_word'(signed'(instr[5:0])) << 1;
	assign offset9 = lc3b_word'(signed'(instr[8:0])) << 1;
	assign offset11 = lc3b_word'(signed'(instr[10:0])) << 1;
	assign pc_next = curr_pc + 16'd2;

	assign is_alu = (opcode == op_add) || (opcode == op_and) || (opcode == op_not);
	assign is_str = (opcode == op_str);
	assign is_ldst = (opcode == op_ldr) || is_str;
	assign is_jsr = (opcode == op_jsr);
	assign reg_jump = (opcode == op_jmp) || (is_jsr && !instr[11]);

	// Register table lookups
	assign regs.sr1_idx = instr[8:6];
	assign regs.sr2_idx = instr[2:0];
	assign regs.dest_idx = instr[11:9];

	// STR reads its store data from the dest field
	assign op2_entry = is_str ? regs.dest_entry : regs.sr2_entry;
	assign rob.rd_tag1 = regs.sr1_entry.tag;
	assign rob.rd_tag2 = op2_entry.tag;

	always_comb
	begin
		j_ready = resolve(regs.sr1_entry, cdb, rob.rd_value1, rob.rd_valid1, j_value);
		k_ready = resolve(op2_entry, cdb, rob.rd_value2, rob.rd_valid2, k_value);
	end

	// Wrong-path slot after a redirect is ignored
	assign live = instr_valid && !shadow;
	assign stall = live && (rob.full
		|| (is_alu && &alu_busy)
		|| (is_ldst && ldst_full)
		|| (reg_jump && !j_ready));
	assign issue = live && !stall;

	assign alu_issue = issue && is_alu;
	assign ldst_issue = issue && is_ldst;

	// Lowest free station wins
	always_comb
	begin
		alu_station = '0;
		for (int i = `ISSUE_ALU_RS - 1; i >= 0; i--)
		begin
			if (!alu_busy[i])
				alu_station = 2'(i);
		end
	end

	assign alu_op = opcode;
	assign alu_dest = rob.tail_tag;
	assign alu_vj = j_value;
	assign alu_qj = j_ready ? '0 : regs.sr1_entry.tag;
	assign alu_j_ready = j_ready;

	always_comb
	begin
		alu_vk = k_value;
		alu_qk = k_ready ? '0 : op2_entry.tag;
		alu_k_ready = k_ready;
		if (opcode == op_not)
		begin
			alu_vk = '1;	// XOR with all ones
			alu_qk = '0;
			alu_k_ready = 1'b1;
		end
		else if (instr[5])	// Immediate form of ADD/AND
		begin
			alu_vk = imm5;
			alu_qk = '0;
			alu_k_ready = 1'b1;
		end
	end

	assign ldst_op = opcode;
	assign ldst_offset = offset6;
	assign ldst_vbase = j_value;
	assign ldst_qbase = j_ready ? '0 : regs.sr1_entry.tag;
	assign ldst_base_ready = j_ready;
	assign ldst_vsrc = k_value;
	assign ldst_qsrc = k_ready ? '0 : op2_entry.tag;
	assign ldst_src_ready = k_ready;
	assign ldst_dest = is_str ? '0 : rob.tail_tag;	// Stores write no register

	// Fetch redirect and values known at issue
	always_comb
	begin
		pcmux_sel = 1'b0;
		br_pc = '0;
		rob.alloc_value = '0;
		case (opcode)
			op_br:
			begin
				br_pc = pc_next + offset9;
				pcmux_sel = issue && predict_bit;
				// Keep the other path for later recovery
				rob.alloc_value = predict_bit ? pc_next : br_pc;
			end
			op_jmp:
			begin
				br_pc = j_value;
				pcmux_sel = issue;
			end
			op_jsr:
			begin
				br_pc = instr[11] ? pc_next + offset11 : j_value;
				pcmux_sel = issue;
				rob.alloc_value = pc_next;	// Link value for R7
			end
			op_lea:
				rob.alloc_value = pc_next + offset9;
			default:
				pcmux_sel = 1'b0;
		endcase
	end

	// JMP needs no ROB entry
	assign rob.alloc = issue && (is_alu || is_ldst || is_jsr
		|| opcode == op_br || opcode == op_lea);
	assign rob.alloc_dest = is_jsr ? 3'd7 : instr[11:9];
	assign rob.alloc_has_dest = is_alu || is_jsr || opcode == op_ldr || opcode == op_lea;
	assign rob.alloc_value_valid = is_jsr || opcode == op_br || opcode == op_lea;

	assign regs.set_busy = rob.alloc && rob.alloc_has_dest;
	assign regs.busy_reg = rob.alloc_dest;
	assign regs.busy_tag = rob.tail_tag;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			shadow <= 1'b0;
		else
			shadow <= pcmux_sel;
	end

	// One issue path per cycle
	assert property (@(posedge clk) disable iff (!rst_n) !(alu_issue && ldst_issue));

endmodule

// File: design/rob_tracker.sv
`timescale 1ns/1ps
`include "issue_settings.svh"

module rob_tracker (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::cdb_t cdb,
	rob_port_if.rob rob,
	reg_port_if.commit commit
);
	import lc3b_pkg::*;

	localparam int rob_depth = `ISSUE_ROB_DEPTH;
	localparam logic [`ISSUE_TAG_W:0] full_count = `ISSUE_ROB_DEPTH;

	lc3b_word value_q [rob_depth];
	lc3b_reg dest_q [rob_depth];
	logic [rob_depth-1:0] has_dest_q;
	logic [rob_depth-1:0] valid_q;	// Result present
	rob_tag_t head;
	rob_tag_t tail;
	logic [`ISSUE_TAG_W:0] count;
	logic do_commit;

	function automatic rob_tag_t next_tag(input rob_tag_t t);
		return (t == rob_tag_t'(rob_depth - 1)) ? '0 : t + 1'b1;
	endfunction

	assign rob.tail_tag = tail;
	assign rob.full = (count == full_count);
	assign rob.rd_value1 = value_q[rob.rd_tag1];
	assign rob.rd_valid1 = valid_q[rob.rd_tag1];
	assign rob.rd_value2 = value_q[rob.rd_tag2];
	assign rob.rd_valid2 = valid_q[rob.rd_tag2];

	// In-order retirement of the head
	assign do_commit = (count != '0) && valid_q[head];
	assign commit.commit_valid = do_commit;
	assign commit.commit_reg = dest_q[head];
	assign commit.commit_tag = head;
	assign commit.commit_value = value_q[head];
	assign commit.commit_has_dest = has_dest_q[head];

	always_ff @(posedge clk)
	begin
		if (rob.alloc)
		begin
			value_q[tail] <= rob.alloc_value;
			dest_q[tail] <= rob.alloc_dest;
			has_dest_q[tail] <= rob.alloc_has_dest;
		end
		if (cdb.valid)
			value_q[cdb.tag] <= cdb.data;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			valid_q <= '0;
		end
		else
		begin
			if (rob.alloc)
			begin
				valid_q[tail] <= rob.alloc_value_valid;
				tail <= next_tag(tail);
			end
			if (cdb.valid)
				valid_q[cdb.tag] <= 1'b1;
			if (do_commit)
			begin
				valid_q[head] <= 1'b0;
				head <= next_tag(head);
			end
			if (rob.alloc && !do_commit)
				count <= count + 1'b1;
			else if (!rob.alloc && do_commit)
				count <= count - 1'b1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) rob.alloc |-> !rob.full);

endmodule

// File: design/issue_top.sv
`timescale 1ns/1ps

module issue_top (
	input logic clk,
	input logic rst_n,
	input lc3b_pkg::lc3b_word instr,
	input logic instr_valid,
	input lc3b_pkg::lc3b_word curr_pc,
	input logic predict_bit,
	input logic [2:0] alu_busy,
	input logic ldst_full,
	input logic cdb_valid,
	input lc3b_pkg::rob_tag_t cdb_tag,
	input lc3b_pkg::lc3b_word cdb_data,
	output logic stall,
	output logic pcmux_sel,
	output lc3b_pkg::lc3b_word br_pc,
	output logic alu_issue,
	output logic [1:0] alu_station,
	output lc3b_pkg::lc3b_opcode alu_op,
	output lc3b_pkg::lc3b_word alu_vj,
	output lc3b_pkg::lc3b_word alu_vk,
	output lc3b_pkg::rob_tag_t alu_qj,
	output lc3b_pkg::rob_tag_t alu_qk,
	output logic alu_j_ready,
	output logic alu_k_ready,
	output lc3b_pkg::rob_tag_t alu_dest,
	output logic ldst_issue,
	output lc3b_pkg::lc3b_opcode ldst_op,
	output lc3b_pkg::lc3b_word ldst_offset,
	output lc3b_pkg::lc3b_word ldst_vbase,
	output lc3b_pkg::rob_tag_t ldst_qbase,
	output logic ldst_base_ready,
	output lc3b_pkg::lc3b_word ldst_vsrc,
	output lc3b_pkg::rob_tag_t ldst_qsrc,
	output logic ldst_src_ready,
	output lc3b_pkg::rob_tag_t ldst_dest,
	output logic commit_valid,
	output lc3b_pkg::lc3b_reg commit_reg,
	output lc3b_pkg::lc3b_word commit_value
);
	import lc3b_pkg::*;

	cdb_t cdb;

	reg_port_if reg_if ();
	rob_port_if rob_if ();

	assign cdb = '{valid: cdb_valid, tag: cdb_tag, data: cdb_data};

	// Commit seen from outside
	assign commit_valid = reg_if.commit_valid;
	assign commit_reg = reg_if.commit_reg;
	assign commit_value = reg_if.commit_value;

	reg_status reg_status_i (
		.clk (clk),
		.rst_n (rst_n),
		.regs (reg_if.reg_table)
	);

	issue_control issue_control_i (
		.clk (clk),
		.rst_n (rst_n),
		.instr (instr),
		.instr_valid (instr_valid),
		.curr_pc (curr_pc),
		.predict_bit (predict_bit),
		.alu_busy (alu_busy),
		.ldst_full (ldst_full),
		.cdb (cdb),
		.regs (reg_if.issue),
		.rob (rob_if.issue),
		.stall (stall),
		.pcmux_sel (pcmux_sel),
		.br_pc (br_pc),
		.alu_issue (alu_issue),
		.alu_station (alu_station),
		.alu_op (alu_op),
		.alu_vj (alu_vj),
		.alu_vk (alu_vk),
		.alu_qj (alu_qj),
		.alu_qk (alu_qk),
		.alu_j_ready (alu_j_ready),
		.alu_k_ready (alu_k_ready),
		.alu_dest (alu_dest),
		.ldst_issue (ldst_issue),
		.ldst_op (ldst_op),
		.ldst_offset (ldst_offset),
		.ldst_vbase (ldst_vbase),
		.ldst_qbase (ldst_qbase),
		.ldst_base_ready (ldst_base_ready),
		.ldst_vsrc (ldst_vsrc),
		.ldst_qsrc (ldst_qsrc),
		.ldst_src_ready (ldst_src_ready),
		.ldst_dest (ldst_dest)
	);

	rob_tracker rob_tracker_i (
		.clk (clk),
		.rst_n (rst_n),
		.cdb (cdb),
		.rob (rob_if.rob),
		.commit (reg_if.commit)
	);

endmodule

// File: verif/issue_tb.sv
`timescale 1ns/1ps

module issue_tb;
	import lc3b_pkg::*;

	localparam int max_cases = 64;
	localparam int n_fields = 27;

	logic clk;
	logic rst_n;
	lc3b_word instr;
	logic instr_valid;
	lc3b_word curr_pc;
	logic predict_bit;
	logic [2:0] alu_busy;
	logic ldst_full;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	lc3b_word cdb_data;

	logic stall;
	logic pcmux_sel;
	lc3b_word br_pc;
	logic alu_issue;
	logic [1:0] alu_station;
	lc3b_opcode alu_op;
	lc3b_word alu_vj;
	lc3b_word alu_vk;
	rob_tag_t alu_qj;
	rob_tag_t alu_qk;
	logic alu_j_ready;
	logic alu_k_ready;
	rob_tag_t alu_dest;
	logic ldst_issue;
	lc3b_opcode ldst_op;
	lc3b_word ldst_offset;
	lc3b_word ldst_vbase;
	rob_tag_t ldst_qbase;
	logic ldst_base_ready;
	lc3b_word ldst_vsrc;
	rob_tag_t ldst_qsrc;
	logic ldst_src_ready;
	rob_tag_t ldst_dest;
	logic commit_valid;
	lc3b_reg commit_reg;
	lc3b_word commit_value;

	logic [15:0] cases [max_cases][n_fields];
	int n_cases;
	int errors;
	int checks;
	time limit_ns;

	issue_top issue_top_i (.*);

	always #10 clk = ~clk;

	task automatic compare_field(input string name, input logic [15:0] got,
		input logic [15:0] exp, input int line_no);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("mismatch %s at case %0d: got %h expected %h", name, line_no, got, exp);
		end
	endtask

	// Columns follow the header of the cases file
	task automatic load_cases();
		int fd;
		int got;
		string line;
		logic [15:0] f [n_fields];
		fd = $fopen("verif/issue_cases.txt", "r");
		n_cases = 0;
		if (fd == 0)
			return;
		while (!$feof(fd) && n_cases < max_cases)
		begin
			line = "";
			got = $fgets(line, fd);
			if (got == 0 || line.len() < 2 || line[0] == "#")
				continue;
			got = $sscanf(line,
				"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
				f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21],
				f[22], f[23], f[24], f[25], f[26]);
			if (got == n_fields)
			begin
				for (int i = 0; i < n_fields; i++)
					cases[n_cases][i] = f[i];
				n_cases++;
			end
		end
		$fclose(fd);
	endtask

	task automatic check_case(input int k);
		compare_field("stall", 16'(stall), cases[k][9], k);
		compare_field("pcmux_sel", 16'(pcmux_sel), cases[k][10], k);
		if (cases[k][10] == 16'h1)
			compare_field("br_pc", br_pc, cases[k][11], k);
		compare_field("alu_issue", 16'(alu_issue), cases[k][12], k);
		if (cases[k][12] == 16'h1)
		begin
			compare_field("alu_op", 16'(alu_op), 16'(cases[k][1][15:12]), k);
			compare_field("alu_station", 16'(alu_station), cases[k][13], k);
			compare_field("alu_vk", alu_vk, cases[k][15], k);
			// Vk is always given as a value, so k is ready and carries no tag
			compare_field("alu_k_ready", 16'(alu_k_ready), 16'h1, k);
			compare_field("alu_qk", 16'(alu_qk), 16'h0, k);
			compare_field("alu_j_ready", 16'(alu_j_ready), cases[k][17], k);
			compare_field("alu_qj", 16'(alu_qj), cases[k][16], k);
			compare_field("alu_dest", 16'(alu_dest), cases[k][18], k);
			if (cases[k][17] == 16'h1)
				compare_field("alu_vj", alu_vj, cases[k][14], k);
		end
		compare_field("ldst_issue", 16'(ldst_issue), cases[k][19], k);
		if (cases[k][19] == 16'h1)
		begin
			compare_field("ldst_op", 16'(ldst_op), 16'(cases[k][1][15:12]), k);
			compare_field("ldst_offset", ldst_offset, cases[k][20], k);
			compare_field("ldst_vbase", ldst_vbase, cases[k][21], k);
			compare_field("ldst_base_ready", 16'(ldst_base_ready), 16'h1, k);
			compare_field("ldst_qbase", 16'(ldst_qbase), 16'h0, k);
			compare_field("ldst_vsrc", ldst_vsrc, cases[k][22], k);
			compare_field("ldst_src_ready", 16'(ldst_src_ready), 16'h1, k);
			compare_field("ldst_qsrc", 16'(ldst_qsrc), 16'h0, k);
			compare_field("ldst_dest", 16'(ldst_dest), cases[k][23], k);
		end
		compare_field("commit_valid", 16'(commit_valid), cases[k][24], k);
		if (cases[k][24] == 16'h1)
		begin
			compare_field("commit_reg", 16'(commit_reg), cases[k][25], k);
			compare_field("commit_value", commit_value, cases[k][26], k);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		curr_pc = '0;
		predict_bit = 1'b0;
		alu_busy = '0;
		ldst_full = 1'b0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_data = '0;
		errors = 0;
		checks = 0;
		limit_ns = 0;
		load_cases();
		if (n_cases == 0)
		begin
			$display("could not read any case from verif/issue_cases.txt");
			errors++;
		end
		else
		begin
			limit_ns = (n_cases + 10) * 20;
			repeat (2) @(negedge clk);
			rst_n = 1'b1;
			for (int k = 0; k < n_cases; k++)
			begin
				@(negedge clk);
				instr_valid = cases[k][0][0];
				instr = cases[k][1];
				curr_pc = cases[k][2];
				predict_bit = cases[k][3][0];
				alu_busy = cases[k][4][2:0];
				ldst_full = cases[k][5][0];
				cdb_valid = cases[k][6][0];
				cdb_tag = cases[k][7][2:0];
				cdb_data = cases[k][8];
				#9;	// Just ahead of the rising edge
				check_case(k);
			end
		end
		@(negedge clk);
		instr_valid = 1'b0;
		cdb_valid = 1'b0;
		$display("cases %0d, checks %0d, errors %0d", n_cases, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		wait (limit_ns > 0);
		#(limit_ns);
		$display("run timed out after %0d ns", limit_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

// File: verif/issue_cases.txt
# in: valid instr pc pred alu_busy ldst_full cdb_valid cdb_tag cdb_data
# exp: stall pcmux br_pc alu_iss stn vj vk qj j_rdy adest ldst_iss off vbase vsrc ldest cmt creg cval
1 12a3 3000 0 0 0 0 0 0000 0 0 0000 1 0 0000 0003 0 1 0 0 0000 0000 0000 0 0 0 0000
0 0000 0000 0 0 0 1 0 0005 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 1641 3002 0 0 0 0 0 0000 0 0 0000 1 0 0005 0005 0 1 1 0 0000 0000 0000 0 1 1 0005
1 18e1 3004 0 0 0 0 0 0000 0 0 0000 1 0 0000 0001 1 0 2 0 0000 0000 0000 0 0 0 0000
1 1ae0 3006 0 0 0 1 1 0010 0 0 0000 1 0 0010 0000 0 1 3 0 0000 0000 0000 0 0 0 0000
0 0000 0000 0 0 0 1 3 0020 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 3 0010
1 1f60 3008 0 0 0 0 0 0000 0 0 0000 1 0 0020 0000 0 1 4 0 0000 0000 0000 0 0 0 0000
1 6442 300a 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 1 0004 0005 0000 5 0 0 0000
1 767f 300c 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 1 fffe 0005 0010 0 0 0 0000
1 6040 300e 0 0 1 0 0 0000 1 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 1061 300e 0 0 1 0 0 0000 0 0 0000 1 0 0005 0001 0 1 7 0 0000 0000 0000 0 0 0 0000
1 1061 3010 0 7 0 0 0 0000 1 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 1260 3010 0 3 0 0 0 0000 0 0 0000 1 2 0005 0000 0 1 0 0 0000 0000 0000 0 0 0 0000
1 1ce0 3012 0 0 0 0 0 0000 0 0 0000 1 0 0010 0000 0 1 1 0 0000 0000 0000 0 0 0 0000
1 1ce0 3014 0 0 0 0 0 0000 1 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
0 0000 0000 0 0 0 1 2 0002 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
0 0000 0000 0 0 0 1 4 0004 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 4 0002
0 0000 0000 0 0 0 1 5 0006 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 5 0020
0 0000 0000 0 0 0 1 6 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 7 0004
0 0000 0000 0 0 0 1 7 0008 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 2 0006
0 0000 0000 0 0 0 1 0 0009 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 3 0000
0 0000 0000 0 0 0 1 1 000a 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 0 0008
0 0000 0000 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 1 0009
0 0000 0000 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 6 000a
1 0e04 3000 1 0 0 0 0 0000 0 1 300a 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 12a3 3002 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 7 3002
1 0e04 3010 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 ec10 3020 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 7 301a
1 4810 3030 0 0 0 0 0 0000 0 1 3052 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 6 3042
1 0000 3052 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 7 3032
1 1b61 3054 0 0 0 0 0 0000 0 0 0000 1 0 0020 0001 0 1 6 0 0000 0000 0000 0 0 0 0000
1 4140 3056 0 0 0 0 0 0000 1 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 4140 3056 0 0 0 1 6 0040 0 1 0040 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 0 0 0000
1 4140 0040 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 5 0040
0 0000 0000 0 0 0 0 0 0000 0 0 0000 0 0 0000 0000 0 0 0 0 0000 0000 0000 0 1 7 3058

// File: tb.f
+incdir+common
common/lc3b_pkg.sv
common/issue_ifs.sv
design/reg_status.sv
issue/issue_control.sv
design/rob_tracker.sv
design/issue_top.sv
verif/issue_tb.sv

// File: Bender.yml
package:
  name: lc3b_issue

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_pkg.sv
      - common/issue_ifs.sv
      - design/reg_status.sv
      - issue/issue_control.sv
      - design/rob_tracker.sv
      - design/issue_top.sv
  - target: test
    files:
      - verif/issue_tb.sv
